// File: quick_spi.f
verilog/spi_pkg.sv
verilog/axi_lite_slave.sv
verilog/spi_regfile.sv
verilog/spi_engine.sv
verilog/quick_spi.sv
sim/quick_spi_sva.sv
sim/quick_spi_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the quick_spi testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module quick_spi_tb \
    -f quick_spi.f --Mdir obj_dir -o quick_spi_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/quick_spi_sim > "$log" 2>&1
run_status=$?
cat "$log"

if [ $run_status -eq 0 ] && grep -qx "sim passed" "$log"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail (exit status $run_status)"
    exit 1
fi

// File: sim/quick_spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module quick_spi_tb;

    localparam int num_rows = 6;

    typedef struct packed {
        logic                            cpol;
        logic                            cpha;
        logic                            rx_en;
        logic                            restart;  // second start written while busy
        logic [spi_pkg::slave_width-1:0] slave;
        logic [7:0]                      divider;
        logic [spi_pkg::count_width-1:0] tx_bits;
        logic [spi_pkg::count_width-1:0] rx_bits;
        logic [spi_pkg::shift_width-1:0] tx_data;
        logic [spi_pkg::shift_width-1:0] miso_data;
    } row_t;

    logic                               s_axi_aclk = 1'b0;
    logic                               s_axi_aresetn;
    logic [spi_pkg::axi_addr_width-1:0] s_axi_awaddr;
    logic                               s_axi_awvalid;
    logic                               s_axi_awready;
    logic [spi_pkg::axi_data_width-1:0] s_axi_wdata;
    logic [spi_pkg::axi_strb_width-1:0] s_axi_wstrb;
    logic                               s_axi_wvalid;
    logic                               s_axi_wready;
    logic [1:0]                         s_axi_bresp;
    logic                               s_axi_bvalid;
    logic                               s_axi_bready;
    logic [spi_pkg::axi_addr_width-1:0] s_axi_araddr;
    logic                               s_axi_arvalid;
    logic                               s_axi_arready;
    logic [spi_pkg::axi_data_width-1:0] s_axi_rdata;
    logic [1:0]                         s_axi_rresp;
    logic                               s_axi_rvalid;
    logic                               s_axi_rready;
    logic                               sclk;
    logic                               mosi;
    logic                               miso = 1'b0;
    logic [spi_pkg::num_slaves-1:0]     ss_n;
    logic                               interrupt;

    row_t                               rows [num_rows];
    row_t                               cur;
    int                                 ss_falls = 0;
    int                                 samples = 0;
    logic [spi_pkg::shift_width-1:0]    mosi_cap = '0;
    logic [spi_pkg::num_slaves-1:0]     ss_prev = '1;
    logic                               sclk_prev = 1'b0;

    quick_spi quick_spi_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .sclk          (sclk),
        .mosi          (mosi),
        .miso          (miso),
        .ss_n          (ss_n),
        .interrupt     (interrupt)
    );

    bind quick_spi quick_spi_sva quick_spi_sva_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rdata   (s_axi_rdata),
        .ss_n          (ss_n)
    );

    always #20 s_axi_aclk = ~s_axi_aclk;

    task automatic confirm(input logic cond, input string what);
        assert (cond) else begin
            $display("check failed: %s", what);
            $display("sim failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic compare_hex(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        assert (got === expected) else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [63:0] low_mask(input int n);
        return (n >= 64) ? '1 : (64'd1 << n) - 64'd1;
    endfunction

    function automatic logic [31:0] ctrl_word(input row_t r, input logic start);
        logic [31:0] word;
        word = '0;
        word[0] = r.cpol;
        word[1] = r.cpha;
        word[4] = r.rx_en;
        word[spi_pkg::ctrl_start_bit] = start;
        word[8 +: spi_pkg::slave_width] = r.slave;
        word[23:16] = r.divider;
        return word;
    endfunction

    // bit that the slave presents for the sample edge with index n
    function automatic logic miso_bit_for(input int n);
        int k;
        k = n - int'(cur.tx_bits);
        if (k >= 0 && k < spi_pkg::shift_width) return cur.miso_data[k];
        return 1'b0;
    endfunction

    task automatic fill_table();
        // cpol cpha rx_en restart slave divider tx_bits rx_bits tx_data miso_data
        rows[0] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0, 7'd8, 7'd8, 64'ha5, 64'hc3};
        rows[1] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'd1, 7'd16, 7'd12, rand64(), rand64()};
        rows[2] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 8'd3, 7'd32, 7'd20, rand64(), rand64()};
        rows[3] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 8'd2, 7'd64, 7'd64, rand64(), rand64()};
        rows[4] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 8'd12, 7'd5, 7'd37, rand64(), rand64()};
        rows[5] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 8'd1, 7'd0, 7'd33, rand64(), rand64()};
    endtask

    task automatic write_reg(input logic [spi_pkg::word_width-1:0] idx,
                             input logic [31:0] data, input logic [3:0] strb);
        int waited;
        s_axi_awaddr  = {idx, 2'b00};
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        waited = 0;
        while (!s_axi_awready) begin
            @(posedge s_axi_aclk);
            #2;
            waited++;
            confirm(waited < 20, "write address and data were not accepted");
        end
        confirm(s_axi_wready, "wready did not rise together with awready");
        @(posedge s_axi_aclk);
        #2;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        confirm(s_axi_bvalid, "no write response after the write was accepted");
        compare_hex("s_axi_bresp", s_axi_bresp, spi_pkg::resp_okay);
        @(posedge s_axi_aclk);  // hold the response back for one cycle
        #2;
        s_axi_bready = 1'b1;
        @(posedge s_axi_aclk);
        #2;
        s_axi_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [spi_pkg::word_width-1:0] idx, output logic [31:0] data);
        int waited;
        s_axi_araddr  = {idx, 2'b00};
        s_axi_arvalid = 1'b1;
        waited = 0;
        while (!s_axi_arready) begin
            @(posedge s_axi_aclk);
            #2;
            waited++;
            confirm(waited < 20, "read address was not accepted");
        end
        @(posedge s_axi_aclk);
        #2;
        s_axi_arvalid = 1'b0;
        confirm(s_axi_rvalid, "no read data after the read was accepted");
        compare_hex("s_axi_rresp", s_axi_rresp, spi_pkg::resp_okay);
        data = s_axi_rdata;
        @(posedge s_axi_aclk);
        #2;
        s_axi_rready = 1'b1;
        @(posedge s_axi_aclk);
        #2;
        s_axi_rready = 1'b0;
    endtask

    task automatic verify_reg(input logic [spi_pkg::word_width-1:0] idx, input string name,
                              input logic [31:0] expected);
        logic [31:0] got;
        read_reg(idx, got);
        compare_hex(name, got, expected);
    endtask

    // writes junk first and then the odd and even bytes of the value in two strobed writes
    task automatic load_split_word(input logic [spi_pkg::word_width-1:0] idx,
                                   input logic [31:0] value);
        logic [31:0] junk;
        junk = $urandom;
        write_reg(idx, junk, 4'hf);
        write_reg(idx, value, 4'b1010);
        verify_reg(idx, "s_axi_rdata merged", {value[31:24], junk[23:16], value[15:8], junk[7:0]});
        write_reg(idx, value, 4'b0101);
    endtask

    // the slave model looks at the pins 1 ns after each clock edge
    always @(posedge s_axi_aclk) begin
        logic [spi_pkg::num_slaves-1:0] ss_expect;
        #1;
        ss_expect = '1;
        ss_expect[cur.slave] = 1'b0;
        if (s_axi_aresetn) begin
            if (ss_n != '1) confirm(ss_n == ss_expect, "a wrong slave select is low");
            if (ss_prev == '1 && ss_n != '1) begin
                ss_falls++;
                samples = 0;
                mosi_cap = '0;
                confirm(sclk == cur.cpol, "sclk not at cpol when the slave was selected");
                miso = miso_bit_for(0);
            end else if (ss_n != '1 && sclk != sclk_prev) begin
                if ((sclk != cur.cpol) != cur.cpha) begin  // sample edge
                    if (samples < int'(cur.tx_bits)) mosi_cap[samples] = mosi;
                    samples++;
                end else begin
                    miso = miso_bit_for(samples);
                end
            end
            if (ss_prev != '1 && ss_n == '1) begin
                confirm(sclk == cur.cpol, "sclk did not return to cpol after the transfer");
            end
        end
        ss_prev = ss_n;
        sclk_prev = sclk;
    end

    initial begin
        longint limit_ns;
        int     max_div;
        #1;
        max_div = 0;
        foreach (rows[i]) if (rows[i].divider > max_div) max_div = rows[i].divider;
        limit_ns = longint'(num_rows) * 130 * 2 * (max_div + 1) * 40 + 200000;
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        $display("sim failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int          waited;
        int          falls_before;
        logic [63:0] rx_expect;
        logic [31:0] got;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        void'($urandom(46));
        fill_table();
        repeat (4) @(posedge s_axi_aclk);
        #2;
        s_axi_aresetn = 1'b1;
        confirm(!interrupt, "interrupt is high after reset");
        confirm(ss_n == '1 && !sclk && !mosi, "spi pins are not idle after reset");
        for (int r = 0; r < num_rows; r++) begin
            cur = rows[r];
            load_split_word(spi_pkg::reg_count, {9'b0, cur.rx_bits, 9'b0, cur.tx_bits});
            load_split_word(spi_pkg::reg_tx_lo, cur.tx_data[31:0]);
            load_split_word(spi_pkg::reg_tx_hi, cur.tx_data[63:32]);
            if (r > 0) confirm(interrupt, "interrupt fell before the next start");
            falls_before = ss_falls;
            write_reg(spi_pkg::reg_ctrl, ctrl_word(cur, 1'b1), 4'hf);
            confirm(!interrupt, "start did not clear interrupt");
            if (cur.restart) begin
                write_reg(spi_pkg::reg_ctrl, ctrl_word(cur, 1'b1), 4'hf);  // lands while busy
                read_reg(spi_pkg::reg_status, got);
                compare_hex("s_axi_rdata status while busy", got, 32'h1);
            end
            waited = 0;
            while (!interrupt) begin
                @(posedge s_axi_aclk);
                #2;
                waited++;
                confirm(waited < 300 * (cur.divider + 1),
                        "interrupt did not rise after the transfer");
            end
            confirm(ss_n == '1, "slave select still low after interrupt");
            confirm(ss_falls == falls_before + 1, "a start did not give exactly one transfer");
            compare_hex("samples", samples,
                        int'(cur.tx_bits) + (cur.rx_en ? int'(cur.rx_bits) : 0));
            compare_hex("mosi", mosi_cap, cur.tx_data & low_mask(cur.tx_bits));
            rx_expect = cur.rx_en ? cur.miso_data & low_mask(cur.rx_bits) : '0;
            verify_reg(spi_pkg::reg_ctrl, "s_axi_rdata ctrl", ctrl_word(cur, 1'b0));
            verify_reg(spi_pkg::reg_count, "s_axi_rdata count",
                       {9'b0, cur.rx_bits, 9'b0, cur.tx_bits});
            verify_reg(spi_pkg::reg_tx_lo, "s_axi_rdata tx_lo", cur.tx_data[31:0]);
            verify_reg(spi_pkg::reg_tx_hi, "s_axi_rdata tx_hi", cur.tx_data[63:32]);
            verify_reg(spi_pkg::reg_rx_lo, "s_axi_rdata rx_lo", rx_expect[31:0]);
            verify_reg(spi_pkg::reg_rx_hi, "s_axi_rdata rx_hi", rx_expect[63:32]);
            verify_reg(spi_pkg::reg_status, "s_axi_rdata status", 32'h2);  // done, not busy
            verify_reg(3'd7, "s_axi_rdata unmapped", 32'h0);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/quick_spi_sva.sv
`timescale 1ns/1ps
`default_nettype none

module quick_spi_sva (
    input wire                               s_axi_aclk,
    input wire                               s_axi_aresetn,
    input wire                               s_axi_bvalid,
    input wire                               s_axi_bready,
    input wire                               s_axi_rvalid,
    input wire                               s_axi_rready,
    input wire [spi_pkg::axi_data_width-1:0] s_axi_rdata,
    input wire [spi_pkg::num_slaves-1:0]     ss_n
);

    bvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("rvalid or rdata changed before rready");

    // never more than one slave selected at a time
    one_select: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $countones(~ss_n) <= 1)
        else $error("more than one slave select is low");

endmodule

`default_nettype wire

// File: verilog/quick_spi.sv
`timescale 1ns/1ps
`default_nettype none

module quick_spi (
    input  wire                                 s_axi_aclk,
    input  wire                                 s_axi_aresetn,
    input  wire [spi_pkg::axi_addr_width-1:0]   s_axi_awaddr,
    input  wire                                 s_axi_awvalid,
    output wire                                 s_axi_awready,
    input  wire [spi_pkg::axi_data_width-1:0]   s_axi_wdata,
    input  wire [spi_pkg::axi_strb_width-1:0]   s_axi_wstrb,
    input  wire                                 s_axi_wvalid,
    output wire                                 s_axi_wready,
    output wire [1:0]                           s_axi_bresp,
    output wire                                 s_axi_bvalid,
    input  wire                                 s_axi_bready,
    input  wire [spi_pkg::axi_addr_width-1:0]   s_axi_araddr,
    input  wire                                 s_axi_arvalid,
    output wire                                 s_axi_arready,
    output wire [spi_pkg::axi_data_width-1:0]   s_axi_rdata,
    output wire [1:0]                           s_axi_rresp,
    output wire                                 s_axi_rvalid,
    input  wire                                 s_axi_rready,
    output wire                                 sclk,
    output wire                                 mosi,
    input  wire                                 miso,
    output wire [spi_pkg::num_slaves-1:0]       ss_n,
    output wire                                 interrupt
);

    spi_pkg::reg_wr_t                   wr;
    spi_pkg::reg_rd_t                   rd;
    logic [spi_pkg::axi_data_width-1:0] rd_data;
    spi_pkg::spi_cfg_t                  cfg;
    spi_pkg::spi_result_t               result;
    logic                               start;
    logic                               busy;

    axi_lite_slave axi_lite_slave_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr            (wr),
        .rd            (rd),
        .rd_data       (rd_data)
    );

    spi_regfile spi_regfile_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr            (wr),
        .rd            (rd),
        .rd_data       (rd_data),
        .cfg           (cfg),
        .start         (start),
        .result        (result),
        .busy          (busy),
        .interrupt     (interrupt)
    );

    spi_engine spi_engine_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .cfg           (cfg),
        .start         (start),
        .busy          (busy),
        .result        (result),
        .sclk          (sclk),
        .mosi          (mosi),
        .miso          (miso),
        .ss_n          (ss_n)
    );

endmodule

`default_nettype wire

// File: verilog/spi_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_engine (
    input  wire                            s_axi_aclk,
    input  wire                            s_axi_aresetn,
    input  spi_pkg::spi_cfg_t              cfg,
    input  wire                            start,
    output logic                           busy,
    output spi_pkg::spi_result_t           result,
    output logic                           sclk,
    output logic                           mosi,
    input  wire                            miso,
    output logic [spi_pkg::num_slaves-1:0] ss_n
);

    typedef enum logic [2:0] {
        st_idle,
        st_select,
        st_write,
        st_read,
        st_end
    } state_t;

    state_t                          state;
    spi_pkg::spi_cfg_t               cfg_q;
    logic [7:0]                      div_cnt;
    logic                            step;
    logic [spi_pkg::count_width-1:0] bit_cnt;
    logic [spi_pkg::shift_width-1:0] tx_q;
    logic [spi_pkg::shift_width-1:0] rx_q;
    logic                            done_q;
    logic                            lead;
    logic                            shift_edge;
    logic                            last_tx;
    logic                            last_rx;
    logic                            read_next;

    assign step = div_cnt == cfg_q.divider;
    assign lead = sclk == cfg_q.cpol;  // the coming toggle leaves the idle level
    // cpha 0 shifts on the trailing edge, cpha 1 on the leading edge
    assign shift_edge = lead == cfg_q.cpha;
    // a bit ends on its trailing edge
    assign last_tx   = !lead && bit_cnt == cfg_q.tx_bits - 1'b1;
    assign last_rx   = !lead && bit_cnt == cfg_q.rx_bits - 1'b1;
    assign read_next = cfg_q.rx_en && cfg_q.rx_bits != '0;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            div_cnt <= '0;
        end else if (state == st_idle || step) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state   <= st_idle;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            ss_n    <= '1;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        cfg_q   <= cfg;
                        tx_q    <= cfg.tx_data;
                        rx_q    <= '0;
                        sclk    <= cfg.cpol;
                        bit_cnt <= '0;
                        state   <= st_select;
                    end
                end
                st_select: begin
                    if (step) begin
                        ss_n[cfg_q.slave] <= 1'b0;
                        if (!cfg_q.cpha) begin
                            mosi <= tx_q[0];  // no edge comes before the first sample
                            tx_q <= tx_q >> 1;
                        end
                        if (cfg_q.tx_bits != '0) state <= st_write;
                        else if (read_next) state <= st_read;
                        else state <= st_end;
                    end
                end
                st_write: begin
                    if (step) begin
                        sclk <= ~sclk;
                        if (shift_edge) begin
                            mosi <= tx_q[0] && !last_tx;
                            tx_q <= tx_q >> 1;
                        end
                        if (!lead) bit_cnt <= bit_cnt + 1'b1;
                        if (last_tx) begin
                            bit_cnt <= '0;
                            state   <= read_next ? st_read : st_end;
                        end
                    end
                end
                st_read: begin
                    if (step) begin
                        sclk <= ~sclk;
                        if (!shift_edge) rx_q[bit_cnt[5:0]] <= miso;
                        if (!lead) bit_cnt <= bit_cnt + 1'b1;
                        if (last_rx) state <= st_end;
                    end
                end
                st_end: begin
                    if (step) begin
                        sclk   <= cfg_q.cpol;
                        mosi   <= 1'b0;
                        ss_n   <= '1;
                        done_q <= 1'b1;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign busy   = state != st_idle;
    assign result = '{rx_data: rx_q, done: done_q};

endmodule

`default_nettype wire

// File: verilog/spi_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module spi_regfile (
    input  wire                                s_axi_aclk,
    input  wire                                s_axi_aresetn,
    input  spi_pkg::reg_wr_t                   wr,
    input  spi_pkg::reg_rd_t                   rd,
    output logic [spi_pkg::axi_data_width-1:0] rd_data,
    output spi_pkg::spi_cfg_t                  cfg,
    output logic                               start,
    input  spi_pkg::spi_result_t               result,
    input  wire                                busy,
    output logic                               interrupt
);

    logic [spi_pkg::axi_data_width-1:0] ctrl_q;
    logic [spi_pkg::axi_data_width-1:0] count_q;
    logic [spi_pkg::axi_data_width-1:0] tx_lo_q;
    logic [spi_pkg::axi_data_width-1:0] tx_hi_q;
    logic [spi_pkg::shift_width-1:0]    rx_q;
    logic                               done_q;
    logic                               start_hit;

    function automatic logic [spi_pkg::axi_data_width-1:0] merge_bytes(
        input logic [spi_pkg::axi_data_width-1:0] old_word,
        input logic [spi_pkg::axi_data_width-1:0] new_word,
        input logic [spi_pkg::axi_strb_width-1:0] strb
    );
        logic [spi_pkg::axi_data_width-1:0] merged;
        merged = old_word;
        for (int b = 0; b < spi_pkg::axi_strb_width; b++) begin
            if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    assign start_hit = wr.valid && wr.idx == spi_pkg::reg_ctrl && wr.strb[0]
                       && wr.data[spi_pkg::ctrl_start_bit];

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ctrl_q  <= '0;
            count_q <= '0;
            start   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start <= start_hit && !busy && !start;  // a start during a transfer is dropped
            if (wr.valid && wr.idx == spi_pkg::reg_ctrl) begin
                ctrl_q <= merge_bytes(ctrl_q, wr.data, wr.strb) & ~(32'h1 << spi_pkg::ctrl_start_bit);
            end
            if (wr.valid && wr.idx == spi_pkg::reg_count) begin
                count_q <= merge_bytes(count_q, wr.data, wr.strb);
            end
            if (start) done_q <= 1'b0;
            else if (result.done) done_q <= 1'b1;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (wr.valid && wr.idx == spi_pkg::reg_tx_lo) tx_lo_q <= merge_bytes(tx_lo_q, wr.data, wr.strb);
        if (wr.valid && wr.idx == spi_pkg::reg_tx_hi) tx_hi_q <= merge_bytes(tx_hi_q, wr.data, wr.strb);
        if (result.done) rx_q <= result.rx_data;
    end

    // the start pulse follows the write by a cycle, so cfg already holds the new byte
    assign cfg.cpol    = ctrl_q[0];
    assign cfg.cpha    = ctrl_q[1];
    assign cfg.rx_en   = ctrl_q[4];
    assign cfg.slave   = ctrl_q[8 +: spi_pkg::slave_width];
    assign cfg.divider = ctrl_q[23:16];
    assign cfg.tx_bits = count_q[spi_pkg::count_width-1:0];
    assign cfg.rx_bits = count_q[16 +: spi_pkg::count_width];
    assign cfg.tx_data = {tx_hi_q, tx_lo_q};

    assign interrupt = done_q;

    always_comb begin
        rd_data = '0;
        if (rd.valid) begin
            case (rd.idx)
                spi_pkg::reg_ctrl:   rd_data = ctrl_q;
                spi_pkg::reg_count:  rd_data = count_q;
                spi_pkg::reg_tx_lo:  rd_data = tx_lo_q;
                spi_pkg::reg_tx_hi:  rd_data = tx_hi_q;
                spi_pkg::reg_rx_lo:  rd_data = rx_q[31:0];
                spi_pkg::reg_rx_hi:  rd_data = rx_q[63:32];
                spi_pkg::reg_status: rd_data = {30'b0, done_q, busy};
                default:             rd_data = '0;  // unmapped words read zero
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
    input  wire                                 s_axi_aclk,
    input  wire                                 s_axi_aresetn,
    input  wire [spi_pkg::axi_addr_width-1:0]   s_axi_awaddr,
    input  wire                                 s_axi_awvalid,
    output logic                                s_axi_awready,
    input  wire [spi_pkg::axi_data_width-1:0]   s_axi_wdata,
    input  wire [spi_pkg::axi_strb_width-1:0]   s_axi_wstrb,
    input  wire                                 s_axi_wvalid,
    output logic                                s_axi_wready,
    output logic [1:0]                          s_axi_bresp,
    output logic                                s_axi_bvalid,
    input  wire                                 s_axi_bready,
    input  wire [spi_pkg::axi_addr_width-1:0]   s_axi_araddr,
    input  wire                                 s_axi_arvalid,
    output logic                                s_axi_arready,
    output logic [spi_pkg::axi_data_width-1:0]  s_axi_rdata,
    output logic [1:0]                          s_axi_rresp,
    output logic                                s_axi_rvalid,
    input  wire                                 s_axi_rready,
    output spi_pkg::reg_wr_t                    wr,
    output spi_pkg::reg_rd_t                    rd,
    input  wire [spi_pkg::axi_data_width-1:0]   rd_data
);

    logic aw_hs;
    logic ar_hs;

    // address and data are taken together, so one ready covers both channels
    assign aw_hs = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
    assign ar_hs = s_axi_arready && s_axi_arvalid;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
        end else begin
            // one cycle pulse, held off while a response is still waiting for bready
            s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
            s_axi_wready  <= s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_bvalid <= 1'b0;
        end else if (aw_hs) begin
            s_axi_bvalid <= 1'b1;
        end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_arready <= 1'b0;
        end else begin
            s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_rvalid <= 1'b0;
        end else if (ar_hs) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (ar_hs) begin
            s_axi_rdata <= rd_data;  // stays put until the host takes it
        end
    end

    assign s_axi_bresp = spi_pkg::resp_okay;
    assign s_axi_rresp = spi_pkg::resp_okay;

    // byte address to word index
    assign wr.idx   = s_axi_awaddr[2 +: spi_pkg::word_width];
    assign wr.data  = s_axi_wdata;
    assign wr.strb  = s_axi_wstrb;
    assign wr.valid = aw_hs;

    assign rd.idx   = s_axi_araddr[2 +: spi_pkg::word_width];
    assign rd.valid = ar_hs;

endmodule

`default_nettype wire

// File: verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

    localparam int axi_addr_width = 5;
    localparam int axi_data_width = 32;
    localparam int axi_strb_width = axi_data_width / 8;
    localparam int word_width     = 3;  // word index taken from axi address bits [4:2]
    localparam int num_slaves     = 2;
    localparam int slave_width    = (num_slaves > 1) ? $clog2(num_slaves) : 1;
    localparam int shift_width    = 64;
    localparam int count_width    = 7;

    localparam logic [word_width-1:0] reg_ctrl   = 3'd0;
    localparam logic [word_width-1:0] reg_count  = 3'd1;
    localparam logic [word_width-1:0] reg_tx_lo  = 3'd2;
    localparam logic [word_width-1:0] reg_tx_hi  = 3'd3;
    localparam logic [word_width-1:0] reg_rx_lo  = 3'd4;
    localparam logic [word_width-1:0] reg_rx_hi  = 3'd5;
    localparam logic [word_width-1:0] reg_status = 3'd6;

    localparam int ctrl_start_bit = 7;

    localparam logic [1:0] resp_okay = 2'b00;

    typedef struct packed {
        logic [word_width-1:0]     idx;
        logic [axi_data_width-1:0] data;
        logic [axi_strb_width-1:0] strb;
        logic                      valid;
    } reg_wr_t;

    typedef struct packed {
        logic [word_width-1:0] idx;
        logic                  valid;
    } reg_rd_t;

    typedef struct packed {
        logic                   cpol;
        logic                   cpha;
        logic                   rx_en;
        logic [slave_width-1:0] slave;
        logic [7:0]             divider;
        logic [count_width-1:0] tx_bits;
        logic [count_width-1:0] rx_bits;
        logic [shift_width-1:0] tx_data;
    } spi_cfg_t;

    typedef struct packed {
        logic [shift_width-1:0] rx_data;
        logic                   done;  // single cycle at the end of a transfer
    } spi_result_t;

endpackage

`default_nettype wire
